// ==== source/cache_geometry_pkg.sv ====
`default_nettype none

package cache_geometry_pkg;

	// Direct-mapped geometry shared by both caches.
	localparam int INDEX_BITS = 6;
	localparam int LINES = 1 << INDEX_BITS;
	localparam int WORD_BITS = 32;
	localparam int TAG_BITS = 30;

	typedef logic [INDEX_BITS-1:0] line_index_t;
	typedef logic [TAG_BITS-1:0] word_tag_t;

	// Data cache entry is {data, word tag, dirty, valid}.
	localparam int DCACHE_ENTRY_BITS = WORD_BITS + TAG_BITS + 2;
	localparam int DC_VALID_BIT = 0;
	localparam int DC_DIRTY_BIT = 1;
	localparam int DC_TAG_LSB = 2;
	localparam int DC_DATA_LSB = DC_TAG_LSB + TAG_BITS;

	// Instruction cache entry is {data, word tag, valid}.
	localparam int ICACHE_ENTRY_BITS = WORD_BITS + TAG_BITS + 1;
	localparam int IC_VALID_BIT = 0;
	localparam int IC_TAG_LSB = 1;
	localparam int IC_DATA_LSB = IC_TAG_LSB + TAG_BITS;

	// Which cache drives the shared memory bus.
	typedef enum logic {
		OWNER_DATA,
		OWNER_INSTR
	} bus_owner_t;

endpackage

`default_nettype wire

// ==== source/memory_map_pkg.sv ====
`default_nettype none

package memory_map_pkg;

	// Byte address and data word of the shared memory bus.
	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;

	// Top address nibble of the SDRAM region, the only region that is cached.
	localparam logic [3:0] CACHEABLE_REGION = 4'h2;

endpackage

`default_nettype wire

// ==== source/line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_store
	import cache_geometry_pkg::*;
#(
	parameter int ENTRY_BITS = 64
) (
	input  wire                    i_clock,
	input  wire                    i_rst,
	input  wire                    i_write,
	input  wire line_index_t       i_index,
	input  wire [ENTRY_BITS-1:0]   i_wdata,
	output logic [ENTRY_BITS-1:0]  o_rdata,
	output logic                   o_initialized
);

	logic [ENTRY_BITS-1:0] entries [LINES];
	line_index_t clear_index;

	// Clears one entry per cycle after reset.
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			clear_index <= '0;
			o_initialized <= 1'b0;
		end else if (!o_initialized) begin
			clear_index <= clear_index + 1'b1;
			if (clear_index == line_index_t'(LINES - 1)) begin
				o_initialized <= 1'b1;
			end
		end
	end

	// All-zero entries are invalid.
	always_ff @(posedge i_clock) begin
		if (!o_initialized) begin
			entries[clear_index] <= '0;
		end else begin
			if (i_write) begin
				entries[i_index] <= i_wdata;
			end
			o_rdata <= entries[i_index];
		end
	end

endmodule

`default_nettype wire

// ==== source/data_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_cache
	import memory_map_pkg::*;
	import cache_geometry_pkg::*;
(
	input  wire            i_clock,
	input  wire            i_rst,
	input  wire            i_request,
	input  wire            i_rw,
	input  wire            i_flush,
	input  wire bus_addr_t i_address,
	input  wire bus_data_t i_wdata,
	output logic           o_ready,
	output bus_data_t      o_rdata,
	output logic           o_bus_request,
	output logic           o_bus_rw,
	output bus_addr_t      o_bus_address,
	output bus_data_t      o_bus_wdata,
	input  wire            i_bus_ready,
	input  wire bus_data_t i_bus_rdata
);

	typedef enum logic [3:0] {
		IDLE,
		FLUSH_SETUP,
		FLUSH_CHECK,
		FLUSH_WRITE,
		PASS_THROUGH,
		WRITE_SETUP,
		WRITE_WAIT,
		READ_SETUP,
		READ_WB_WAIT,
		READ_BUS_WAIT
	} state_t;

	state_t state;
	state_t next_state;
	logic [INDEX_BITS:0] flush_count;
	logic [INDEX_BITS:0] next_flush_count;
	logic ready_next;
	bus_data_t rdata_next;
	logic write_back;

	logic store_write;
	line_index_t store_index;
	logic [DCACHE_ENTRY_BITS-1:0] store_wdata;
	logic [DCACHE_ENTRY_BITS-1:0] store_rdata;
	logic store_initialized;

	line_store #(
		.ENTRY_BITS(DCACHE_ENTRY_BITS)
	) store (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_write(store_write),
		.i_index(store_index),
		.i_wdata(store_wdata),
		.o_rdata(store_rdata),
		.o_initialized(store_initialized)
	);

	logic is_cacheable;
	word_tag_t request_tag;
	line_index_t request_index;
	logic entry_victim;
	logic entry_hit;
	word_tag_t entry_tag;
	bus_data_t entry_data;

	assign is_cacheable = i_address[31:28] == CACHEABLE_REGION;
	assign request_tag = i_address[31:2];
	assign request_index = i_address[INDEX_BITS+1:2];
	assign entry_tag = store_rdata[DC_TAG_LSB +: TAG_BITS];
	assign entry_data = store_rdata[DC_DATA_LSB +: WORD_BITS];
	assign entry_hit = store_rdata[DC_VALID_BIT] && entry_tag == request_tag;
	// Valid and dirty, so memory holds stale data.
	assign entry_victim = store_rdata[DC_VALID_BIT] && store_rdata[DC_DIRTY_BIT];

	always_comb begin
		next_state = state;
		next_flush_count = flush_count;
		ready_next = 1'b0;
		rdata_next = '0;
		write_back = 1'b0;
		store_write = 1'b0;
		store_index = request_index;
		store_wdata = {i_wdata, request_tag, 1'b1, 1'b1};
		o_bus_request = 1'b0;
		o_bus_rw = 1'b0;
		o_bus_address = '0;
		o_bus_wdata = '0;

		case (state)
			IDLE: begin
				// Ready is still high for the previous request.
				if (i_request && !o_ready) begin
					if (i_flush) begin
						if (store_initialized) begin
							next_flush_count = '0;
							next_state = FLUSH_SETUP;
						end else begin
							ready_next = 1'b1;
						end
					end else if (store_initialized && is_cacheable) begin
						next_state = i_rw ? WRITE_SETUP : READ_SETUP;
					end else begin
						next_state = PASS_THROUGH;
					end
				end
			end

			// ====================================================================
			// Flush
			// ====================================================================
			FLUSH_SETUP: begin
				store_index = flush_count[INDEX_BITS-1:0];
				if (flush_count[INDEX_BITS]) begin
					ready_next = 1'b1;
					next_state = IDLE;
				end else begin
					next_state = FLUSH_CHECK;
				end
			end
			FLUSH_CHECK: begin
				store_index = flush_count[INDEX_BITS-1:0];
				if (entry_victim) begin
					next_state = FLUSH_WRITE;
				end else begin
					next_flush_count = flush_count + 1'b1;
					next_state = FLUSH_SETUP;
				end
			end
			FLUSH_WRITE: begin
				store_index = flush_count[INDEX_BITS-1:0];
				store_wdata = {entry_data, entry_tag, 1'b0, 1'b1};
				write_back = 1'b1;
				if (i_bus_ready) begin
					store_write = 1'b1;
					next_flush_count = flush_count + 1'b1;
					next_state = FLUSH_SETUP;
				end
			end

			PASS_THROUGH: begin
				o_bus_request = 1'b1;
				o_bus_rw = i_rw;
				o_bus_address = i_address;
				o_bus_wdata = i_wdata;
				if (i_bus_ready) begin
					ready_next = 1'b1;
					rdata_next = i_bus_rdata;
					next_state = IDLE;
				end
			end

			// ====================================================================
			// Write and read
			// ====================================================================
			WRITE_SETUP: begin
				if (entry_victim && entry_tag != request_tag) begin
					next_state = WRITE_WAIT;
				end else begin
					store_write = 1'b1;
					ready_next = 1'b1;
					next_state = IDLE;
				end
			end
			WRITE_WAIT: begin
				write_back = 1'b1;
				if (i_bus_ready) begin
					store_write = 1'b1;
					ready_next = 1'b1;
					next_state = IDLE;
				end
			end
			READ_SETUP: begin
				if (entry_hit) begin
					ready_next = 1'b1;
					rdata_next = entry_data;
					next_state = IDLE;
				end else begin
					next_state = entry_victim ? READ_WB_WAIT : READ_BUS_WAIT;
				end
			end
			READ_WB_WAIT: begin
				write_back = 1'b1;
				if (i_bus_ready) begin
					next_state = READ_BUS_WAIT;
				end
			end
			READ_BUS_WAIT: begin
				o_bus_request = 1'b1;
				o_bus_address = i_address;
				store_wdata = {i_bus_rdata, request_tag, 1'b0, 1'b1};
				if (i_bus_ready) begin
					store_write = 1'b1;
					ready_next = 1'b1;
					rdata_next = i_bus_rdata;
					next_state = IDLE;
				end
			end
			default: begin
				next_state = IDLE;
			end
		endcase

		if (write_back) begin
			o_bus_request = 1'b1;
			o_bus_rw = 1'b1;
			o_bus_address = {entry_tag, 2'b00};
			o_bus_wdata = entry_data;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= IDLE;
			flush_count <= '0;
			o_ready <= 1'b0;
		end else begin
			state <= next_state;
			flush_count <= next_flush_count;
			o_ready <= ready_next;
		end
	end

	always_ff @(posedge i_clock) begin
		o_rdata <= rdata_next;
	end

endmodule

`default_nettype wire

// ==== source/instr_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_cache
	import memory_map_pkg::*;
	import cache_geometry_pkg::*;
(
	input  wire            i_clock,
	input  wire            i_rst,
	input  wire            i_request,
	input  wire bus_addr_t i_address,
	output logic           o_ready,
	output bus_data_t      o_instr,
	output logic           o_bus_request,
	output bus_addr_t      o_bus_address,
	input  wire            i_bus_ready,
	input  wire bus_data_t i_bus_rdata
);

	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		FILL_WAIT,
		PASS_THROUGH
	} state_t;

	state_t state;
	state_t next_state;
	logic ready_next;
	bus_data_t instr_next;

	logic store_write;
	logic [ICACHE_ENTRY_BITS-1:0] store_wdata;
	logic [ICACHE_ENTRY_BITS-1:0] store_rdata;
	logic store_initialized;

	line_store #(
		.ENTRY_BITS(ICACHE_ENTRY_BITS)
	) store (
		.i_clock(i_clock),
		.i_rst(i_rst),
		.i_write(store_write),
		.i_index(i_address[INDEX_BITS+1:2]),
		.i_wdata(store_wdata),
		.o_rdata(store_rdata),
		.o_initialized(store_initialized)
	);

	logic is_cacheable;
	word_tag_t request_tag;
	logic entry_hit;

	assign is_cacheable = i_address[31:28] == CACHEABLE_REGION;
	assign request_tag = i_address[31:2];
	assign entry_hit = store_rdata[IC_VALID_BIT]
		&& store_rdata[IC_TAG_LSB +: TAG_BITS] == request_tag;
	assign store_wdata = {i_bus_rdata, request_tag, 1'b1};

	// Fill and pass-through both read the fetch address.
	assign o_bus_request = state == FILL_WAIT || state == PASS_THROUGH;
	assign o_bus_address = i_address;

	always_comb begin
		next_state = state;
		ready_next = 1'b0;
		instr_next = '0;
		store_write = 1'b0;
		case (state)
			IDLE: begin
				if (i_request && !o_ready) begin
					next_state = (store_initialized && is_cacheable) ? LOOKUP : PASS_THROUGH;
				end
			end
			LOOKUP: begin
				if (entry_hit) begin
					ready_next = 1'b1;
					instr_next = store_rdata[IC_DATA_LSB +: WORD_BITS];
					next_state = IDLE;
				end else begin
					next_state = FILL_WAIT;
				end
			end
			FILL_WAIT, PASS_THROUGH: begin
				if (i_bus_ready) begin
					store_write = state == FILL_WAIT;
					ready_next = 1'b1;
					instr_next = i_bus_rdata;
					next_state = IDLE;
				end
			end
			default: begin
				next_state = IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= IDLE;
			o_ready <= 1'b0;
		end else begin
			state <= next_state;
			o_ready <= ready_next;
		end
	end

	always_ff @(posedge i_clock) begin
		o_instr <= instr_next;
	end

endmodule

`default_nettype wire

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
	import memory_map_pkg::*;
	import cache_geometry_pkg::*;
(
	input  wire            i_clock,
	input  wire            i_rst,
	input  wire            i_data_request,
	input  wire            i_data_rw,
	input  wire bus_addr_t i_data_address,
	input  wire bus_data_t i_data_wdata,
	output logic           o_data_ready,
	input  wire            i_instr_request,
	input  wire bus_addr_t i_instr_address,
	output logic           o_instr_ready,
	output bus_data_t      o_rdata,
	output logic           o_bus_request,
	output logic           o_bus_rw,
	output bus_addr_t      o_bus_address,
	output bus_data_t      o_bus_wdata,
	input  wire            i_bus_ready,
	input  wire bus_data_t i_bus_rdata
);

	bus_owner_t owner;
	logic owner_idle;
	bus_owner_t grant;
	logic owner_request;
	logic grant_request;

	// Owner holds the bus while it keeps requesting, otherwise the data side wins.
	always_comb begin
		owner_request = (owner == OWNER_DATA) ? i_data_request : i_instr_request;
		if (!owner_idle && owner_request) begin
			grant = owner;
		end else if (i_data_request) begin
			grant = OWNER_DATA;
		end else begin
			grant = OWNER_INSTR;
		end
		grant_request = (grant == OWNER_DATA) ? i_data_request : i_instr_request;
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			owner <= OWNER_DATA;
			owner_idle <= 1'b1;
		end else begin
			owner <= grant;
			owner_idle <= !grant_request;
		end
	end

	// ====================================================================
	// Bus routing
	// ====================================================================
	always_comb begin
		if (grant == OWNER_DATA) begin
			o_bus_request = i_data_request;
			o_bus_rw = i_data_rw;
			o_bus_address = i_data_address;
			o_bus_wdata = i_data_wdata;
		end else begin
			o_bus_request = i_instr_request;
			o_bus_rw = 1'b0;
			o_bus_address = i_instr_address;
			o_bus_wdata = '0;
		end
	end

	assign o_data_ready = i_bus_ready && grant == OWNER_DATA && i_data_request;
	assign o_instr_ready = i_bus_ready && grant == OWNER_INSTR && i_instr_request;
	assign o_rdata = i_bus_rdata;

endmodule

`default_nettype wire

// ==== source/cache_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem
	import memory_map_pkg::*;
(
	input  wire            i_clock,
	input  wire            i_rst,
	input  wire            i_data_request,
	input  wire            i_data_rw,
	input  wire            i_data_flush,
	input  wire bus_addr_t i_data_address,
	input  wire bus_data_t i_data_wdata,
	output logic           o_data_ready,
	output bus_data_t      o_data_rdata,
	input  wire            i_fetch_request,
	input  wire bus_addr_t i_fetch_address,
	output logic           o_fetch_ready,
	output bus_data_t      o_fetch_instr,
	output logic           o_mem_request,
	output logic           o_mem_rw,
	output bus_addr_t      o_mem_address,
	output bus_data_t      o_mem_wdata,
	input  wire            i_mem_ready,
	input  wire bus_data_t i_mem_rdata
);

	logic dc_bus_request;
	logic dc_bus_rw;
	logic dc_bus_ready;
	bus_addr_t dc_bus_address;
	bus_data_t dc_bus_wdata;
	logic ic_bus_request;
	logic ic_bus_ready;
	bus_addr_t ic_bus_address;
	bus_data_t shared_rdata;

	data_cache dcache (
		.i_clock(i_clock), .i_rst(i_rst),
		.i_request(i_data_request), .i_rw(i_data_rw), .i_flush(i_data_flush),
		.i_address(i_data_address), .i_wdata(i_data_wdata),
		.o_ready(o_data_ready), .o_rdata(o_data_rdata),
		.o_bus_request(dc_bus_request), .o_bus_rw(dc_bus_rw),
		.o_bus_address(dc_bus_address), .o_bus_wdata(dc_bus_wdata),
		.i_bus_ready(dc_bus_ready), .i_bus_rdata(shared_rdata)
	);

	instr_cache icache (
		.i_clock(i_clock), .i_rst(i_rst),
		.i_request(i_fetch_request), .i_address(i_fetch_address),
		.o_ready(o_fetch_ready), .o_instr(o_fetch_instr),
		.o_bus_request(ic_bus_request), .o_bus_address(ic_bus_address),
		.i_bus_ready(ic_bus_ready), .i_bus_rdata(shared_rdata)
	);

	bus_arbiter arbiter (
		.i_clock(i_clock), .i_rst(i_rst),
		.i_data_request(dc_bus_request), .i_data_rw(dc_bus_rw),
		.i_data_address(dc_bus_address), .i_data_wdata(dc_bus_wdata),
		.o_data_ready(dc_bus_ready),
		.i_instr_request(ic_bus_request), .i_instr_address(ic_bus_address),
		.o_instr_ready(ic_bus_ready),
		.o_rdata(shared_rdata),
		.o_bus_request(o_mem_request), .o_bus_rw(o_mem_rw),
		.o_bus_address(o_mem_address), .o_bus_wdata(o_mem_wdata),
		.i_bus_ready(i_mem_ready), .i_bus_rdata(i_mem_rdata)
	);

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 4,
	parameter int RESET_CYCLES = 10
) (
	output logic o_clock,
	output logic o_rst
);

	initial begin
		o_clock = 1'b0;
		forever #(PERIOD_NS / 2) o_clock = ~o_clock;
	end

	// Reset drops shortly after a rising edge, like every other input.
	initial begin
		o_rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		#1;
		o_rst = 1'b0;
	end

endmodule

`default_nettype wire

// ==== verification/tb_memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_memory_model
	import memory_map_pkg::*;
(
	input  wire            i_clock,
	input  wire            i_rst,
	input  wire            i_request,
	input  wire            i_rw,
	input  wire bus_addr_t i_address,
	input  wire bus_data_t i_wdata,
	output logic           o_ready,
	output bus_data_t      o_rdata,
	output int             o_read_count,
	output int             o_write_count,
	output int             o_beat_errors
);

	localparam int WORDS = 4096;

	bus_data_t words [WORDS];
	integer seed = 32'h2b3a_ba31;
	logic busy;
	int wait_count;
	bus_addr_t beat_address;
	logic beat_rw;
	logic [11:0] slot;

	assign slot = i_address[13:2];

	// Each word holds its own 12-bit index twice.
	initial begin
		o_ready = 1'b0;
		o_rdata = '0;
		for (int i = 0; i < WORDS; i++) begin
			words[i] = {4'hc, 12'(i), 4'h3, 12'(i)};
		end
	end

	always @(posedge i_clock) begin
		if (i_rst) begin
			o_ready <= 1'b0;
			o_rdata <= '0;
			busy <= 1'b0;
			wait_count <= 0;
			o_read_count <= 0;
			o_write_count <= 0;
			o_beat_errors <= 0;
		end else begin
			o_ready <= 1'b0;
			if (busy) begin
				// A beat must keep its request, direction and address until ready.
				if (!i_request || i_rw != beat_rw || i_address != beat_address) begin
					o_beat_errors <= o_beat_errors + 1;
				end
				if (wait_count == 0) begin
					busy <= 1'b0;
					o_ready <= 1'b1;
					if (beat_rw) begin
						words[slot] <= i_wdata;
						o_write_count <= o_write_count + 1;
					end else begin
						o_rdata <= words[slot];
						o_read_count <= o_read_count + 1;
					end
				end else begin
					wait_count <= wait_count - 1;
				end
			end else if (i_request && !o_ready) begin
				busy <= 1'b1;
				beat_address <= i_address;
				beat_rw <= i_rw;
				wait_count <= $random(seed) & 3;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verification/tb_cache_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache_subsystem
	import memory_map_pkg::*;
	import cache_geometry_pkg::*;
();

	localparam int TIMEOUT_CYCLES = 1000;
	localparam int WARMUP_ROUNDS = 100;
	localparam int MEM_WORDS = 4096;
	localparam int NO_CHECK = -1;

	localparam bus_addr_t NO_ADDR = 32'h0000_0000;
	localparam bus_addr_t ADDR_A = 32'h2000_0010;
	localparam bus_addr_t ADDR_B = 32'h2000_0110;
	localparam bus_addr_t ADDR_C = 32'h2000_0020;
	localparam bus_addr_t ADDR_D = 32'h2000_0030;
	localparam bus_addr_t IO_LOW = 32'h1000_0800;
	localparam bus_addr_t IO_HIGH = 32'h8000_0c04;
	localparam bus_addr_t FETCH_A = 32'h2000_0400;
	localparam bus_addr_t FETCH_B = 32'h2000_0408;
	localparam bus_addr_t FETCH_IO = 32'h0000_0a00;
	localparam bus_addr_t WARMUP_ADDR = 32'h1000_0900;

	typedef enum logic [1:0] {
		OP_NONE,
		OP_READ,
		OP_WRITE,
		OP_FLUSH
	} op_t;

	typedef struct packed {
		op_t op;
		bus_addr_t address;
		bus_data_t wdata;
		bus_addr_t fetch_address;
		bus_addr_t victim_address;
		int reads;
		int writes;
		int latency;
	} row_t;

	// ======================================================================
	// Stimulus table
	// ======================================================================
	// Data op, data address, write data, fetch in the same cycle, evicted line,
	// memory reads, memory writes, latency of the data side (fetch if no data op).
	localparam int ROW_COUNT = 22;
	localparam row_t ROWS [ROW_COUNT] = '{
		'{OP_READ, ADDR_A, 32'h0, NO_ADDR, NO_ADDR, 1, 0, NO_CHECK},
		'{OP_READ, ADDR_A, 32'h0, NO_ADDR, NO_ADDR, 0, 0, 2},
		'{OP_WRITE, ADDR_A, 32'h1111_aaaa, NO_ADDR, NO_ADDR, 0, 0, 2},
		'{OP_READ, ADDR_A, 32'h0, NO_ADDR, NO_ADDR, 0, 0, 2},
		'{OP_WRITE, ADDR_B, 32'h2222_bbbb, NO_ADDR, ADDR_A, 0, 1, NO_CHECK},
		'{OP_READ, ADDR_B, 32'h0, NO_ADDR, NO_ADDR, 0, 0, 2},
		'{OP_READ, ADDR_A, 32'h0, NO_ADDR, ADDR_B, 1, 1, NO_CHECK},
		'{OP_WRITE, ADDR_C, 32'h3333_cccc, NO_ADDR, NO_ADDR, 0, 0, 2},
		'{OP_WRITE, IO_LOW, 32'h4444_dddd, NO_ADDR, NO_ADDR, 0, 1, NO_CHECK},
		'{OP_READ, IO_LOW, 32'h0, NO_ADDR, NO_ADDR, 1, 0, NO_CHECK},
		'{OP_READ, IO_HIGH, 32'h0, NO_ADDR, NO_ADDR, 1, 0, NO_CHECK},
		'{OP_WRITE, IO_HIGH, 32'h5555_eeee, NO_ADDR, NO_ADDR, 0, 1, NO_CHECK},
		'{OP_NONE, NO_ADDR, 32'h0, FETCH_A, NO_ADDR, 1, 0, NO_CHECK},
		'{OP_NONE, NO_ADDR, 32'h0, FETCH_A, NO_ADDR, 0, 0, 2},
		'{OP_NONE, NO_ADDR, 32'h0, FETCH_IO, NO_ADDR, 1, 0, NO_CHECK},
		'{OP_WRITE, ADDR_A, 32'h6666_ffff, NO_ADDR, NO_ADDR, 0, 0, 2},
		'{OP_FLUSH, NO_ADDR, 32'h0, NO_ADDR, NO_ADDR, 0, 2, NO_CHECK},
		'{OP_FLUSH, NO_ADDR, 32'h0, NO_ADDR, NO_ADDR, 0, 0, NO_CHECK},
		'{OP_READ, ADDR_A, 32'h0, NO_ADDR, NO_ADDR, 0, 0, 2},
		'{OP_READ, ADDR_D, 32'h0, FETCH_B, NO_ADDR, 2, 0, NO_CHECK},
		'{OP_WRITE, IO_LOW, 32'h7777_1234, FETCH_A, NO_ADDR, 0, 1, NO_CHECK},
		'{OP_READ, ADDR_B, 32'h0, FETCH_IO, NO_ADDR, 2, 0, NO_CHECK}
	};

	logic clock;
	logic rst;
	logic data_request;
	logic data_rw;
	logic data_flush;
	bus_addr_t data_address;
	bus_data_t data_wdata;
	logic data_ready;
	bus_data_t data_rdata;
	logic fetch_request;
	bus_addr_t fetch_address;
	logic fetch_ready;
	bus_data_t fetch_instr;
	logic mem_request;
	logic mem_rw;
	bus_addr_t mem_address;
	bus_data_t mem_wdata;
	logic mem_ready;
	bus_data_t mem_rdata;
	int mem_reads;
	int mem_writes;
	int beat_errors;
	int cycles = 0;

	// Latest value the CPU wrote to each memory word.
	bus_data_t shadow [MEM_WORDS];
	bus_addr_t written [$];

	tb_clock_gen #(
		.PERIOD_NS(4),
		.RESET_CYCLES(10)
	) clock0 (
		.o_clock(clock),
		.o_rst(rst)
	);

	cache_subsystem dut0 (
		.i_clock(clock), .i_rst(rst),
		.i_data_request(data_request), .i_data_rw(data_rw), .i_data_flush(data_flush),
		.i_data_address(data_address), .i_data_wdata(data_wdata),
		.o_data_ready(data_ready), .o_data_rdata(data_rdata),
		.i_fetch_request(fetch_request), .i_fetch_address(fetch_address),
		.o_fetch_ready(fetch_ready), .o_fetch_instr(fetch_instr),
		.o_mem_request(mem_request), .o_mem_rw(mem_rw),
		.o_mem_address(mem_address), .o_mem_wdata(mem_wdata),
		.i_mem_ready(mem_ready), .i_mem_rdata(mem_rdata)
	);

	tb_memory_model mem0 (
		.i_clock(clock), .i_rst(rst),
		.i_request(mem_request), .i_rw(mem_rw),
		.i_address(mem_address), .i_wdata(mem_wdata),
		.o_ready(mem_ready), .o_rdata(mem_rdata),
		.o_read_count(mem_reads), .o_write_count(mem_writes),
		.o_beat_errors(beat_errors)
	);

	always @(posedge clock) begin
		if (rst) begin
			cycles <= 0;
		end else begin
			cycles <= cycles + 1;
		end
	end

	function automatic int slot_of(input bus_addr_t address);
		return int'(address[13:2]);
	endfunction

	// Same pattern as the memory model holds after power-up.
	function automatic bus_data_t fill_value(input int slot);
		logic [11:0] index;
		index = slot[11:0];
		return {4'hc, index, 4'h3, index};
	endfunction

	// ======================================================================
	// Checks
	// ======================================================================
	task automatic fail_run(input string message);
		$display("%s", message);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic check_data(input bus_data_t actual, input bus_data_t expected,
			input string what);
		if (actual !== expected) begin
			fail_run($sformatf("error at %0t: %s is %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_count(input int actual, input int expected, input string what);
		if (expected != NO_CHECK && actual != expected) begin
			fail_run($sformatf("error at %0t: %s is %0d, expected %0d",
				$time, what, actual, expected));
		end
	endtask

	// ======================================================================
	// Port drivers
	// ======================================================================
	task automatic wait_reset_release();
		int waited;
		waited = 0;
		do begin
			@(posedge clock);
			#1;
			waited++;
		end while (rst !== 1'b0 && waited < TIMEOUT_CYCLES);
		if (rst !== 1'b0) begin
			fail_run("Reset was never released.");
		end
	endtask

	task automatic data_access(input logic rw, input logic flush, input bus_addr_t address,
			input bus_data_t wdata, output bus_data_t rdata, output int latency);
		int waited;
		@(posedge clock);
		#1;
		data_request = 1'b1;
		data_rw = rw;
		data_flush = flush;
		data_address = address;
		data_wdata = wdata;
		waited = 0;
		do begin
			@(posedge clock);
			#1;
			waited++;
		end while (data_ready !== 1'b1 && waited < TIMEOUT_CYCLES);
		if (data_ready !== 1'b1) begin
			fail_run($sformatf("Data port request to %h was never answered.", address));
		end
		rdata = data_rdata;
		latency = waited;
		data_request = 1'b0;
		data_flush = 1'b0;
	endtask

	task automatic fetch_access(input bus_addr_t address, output bus_data_t instr,
			output int latency);
		int waited;
		@(posedge clock);
		#1;
		fetch_request = 1'b1;
		fetch_address = address;
		waited = 0;
		do begin
			@(posedge clock);
			#1;
			waited++;
		end while (fetch_ready !== 1'b1 && waited < TIMEOUT_CYCLES);
		if (fetch_ready !== 1'b1) begin
			fail_run($sformatf("Fetch from %h was never answered.", address));
		end
		instr = fetch_instr;
		latency = waited;
		fetch_request = 1'b0;
	endtask

	task automatic run_row(input int number, input row_t row);
		bus_data_t rdata;
		bus_data_t instr;
		int latency;
		int fetch_latency;
		int reads_before;
		int writes_before;
		string tag;
		reads_before = mem_reads;
		writes_before = mem_writes;
		tag = $sformatf("row %0d", number);
		latency = 0;
		fetch_latency = 0;
		// Both ports start in the same cycle when a row uses both.
		fork
			begin
				if (row.op != OP_NONE) begin
					data_access(row.op == OP_WRITE, row.op == OP_FLUSH, row.address,
						row.wdata, rdata, latency);
				end
			end
			begin
				if (row.fetch_address != NO_ADDR) begin
					fetch_access(row.fetch_address, instr, fetch_latency);
				end
			end
		join
		if (row.op == OP_READ) begin
			check_data(rdata, shadow[slot_of(row.address)], {tag, " read data"});
		end
		if (row.op == OP_WRITE) begin
			shadow[slot_of(row.address)] = row.wdata;
			written.push_back(row.address);
		end
		if (row.fetch_address != NO_ADDR) begin
			check_data(instr, shadow[slot_of(row.fetch_address)], {tag, " fetched word"});
		end
		check_count(mem_reads - reads_before, row.reads, {tag, " memory reads"});
		check_count(mem_writes - writes_before, row.writes, {tag, " memory writes"});
		check_count(row.op != OP_NONE ? latency : fetch_latency, row.latency,
			{tag, " latency"});
		check_count(beat_errors, 0, {tag, " bus transfers changed before ready"});
		if (row.victim_address != NO_ADDR) begin
			check_data(mem0.words[slot_of(row.victim_address)],
				shadow[slot_of(row.victim_address)], {tag, " written-back word"});
		end
		if (row.op == OP_FLUSH) begin
			foreach (written[i]) begin
				check_data(mem0.words[slot_of(written[i])], shadow[slot_of(written[i])],
					{tag, " memory after flush"});
			end
		end
	endtask

	initial begin
		bus_data_t rdata;
		int latency;
		int reads_before;
		int rounds;
		data_request = 1'b0;
		data_rw = 1'b0;
		data_flush = 1'b0;
		data_address = '0;
		data_wdata = '0;
		fetch_request = 1'b0;
		fetch_address = '0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			shadow[i] = fill_value(i);
		end
		wait_reset_release();

		// Uncached reads keep the port busy while both stores clear.
		rounds = 0;
		while (cycles <= LINES + 8 && rounds < WARMUP_ROUNDS) begin
			reads_before = mem_reads;
			data_access(1'b0, 1'b0, WARMUP_ADDR, '0, rdata, latency);
			check_data(rdata, shadow[slot_of(WARMUP_ADDR)], "warm-up read data");
			check_count(mem_reads - reads_before, 1, "warm-up memory reads");
			rounds++;
		end
		if (cycles <= LINES + 8) begin
			fail_run("The caches did not finish clearing their storage in time.");
		end

		for (int i = 0; i < ROW_COUNT; i++) begin
			run_row(i, ROWS[i]);
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== cache_subsystem.f ====
source/cache_geometry_pkg.sv
source/memory_map_pkg.sv
source/line_store.sv
source/data_cache.sv
source/instr_cache.sv
source/bus_arbiter.sv
source/cache_subsystem.sv
verification/tb_clock_gen.sv
verification/tb_memory_model.sv
verification/tb_cache_subsystem.sv

// ==== Bender.yml ====
package:
  name: cache_subsystem

sources:
  - source/cache_geometry_pkg.sv
  - source/memory_map_pkg.sv
  - source/line_store.sv
  - source/data_cache.sv
  - source/instr_cache.sv
  - source/bus_arbiter.sv
  - source/cache_subsystem.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_memory_model.sv
      - verification/tb_cache_subsystem.sv
